// File: flist.f
+incdir+include
logic/gpuPkg.sv
logic/instrDecoder.sv
logic/pcRedirect.sv
logic/decodeLatch.sv
logic/decodeStage.sv
sim/decodeStage_sva.sv
sim/decodeStage_tb.sv

// File: include/gpu_macros.svh
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// Warps per SIMT core
`define NUM_WARPS 8

// Instruction and address word width
`define INSTR_W 32

// Register file has 32 entries
`define REG_IDX_W 5

// Raw I-format immediate
`define IMM_W 16

`endif

// File: logic/decodeLatch.sv
`timescale 1ns/1ps
`default_nettype none

module decodeLatch (
	input  logic                clk,
	input  logic                reset,
	input  gpuPkg::decodedInstr lane0In,
	input  gpuPkg::decodedInstr lane1In,
	output gpuPkg::decodedInstr lane0Out,
	output gpuPkg::decodedInstr lane1Out
);
	import gpuPkg::*;

	localparam int numLanes = 2;

	decodedInstr laneIn  [numLanes];
	decodedInstr laneReg [numLanes];

	assign laneIn[0] = lane0In;
	assign laneIn[1] = lane1In;

	// New pair every clock, no stall path
	always_ff @(posedge clk) begin
		for (int i = 0; i < numLanes; i++) begin
			laneReg[i] <= laneIn[i];
			if (reset) begin
				// Zero masks make every other field a don't-care
				laneReg[i].ibMask   <= '0;
				laneReg[i].simtMask <= '0;
			end
		end
	end

	assign lane0Out = laneReg[0];
	assign lane1Out = laneReg[1];

endmodule

`default_nettype wire

// File: logic/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_macros.svh"

module decodeStage (
	input  logic                clk,
	input  logic                reset,
	input  gpuPkg::fetchSlot    fetch0,
	input  gpuPkg::fetchSlot    fetch1,
	output gpuPkg::decodedInstr issue0, // To I-buffer and SIMT stack
	output gpuPkg::decodedInstr issue1,
	output gpuPkg::warpMask     pcUpdateMask,
	output gpuPkg::warpMask     pcValidMask,
	output gpuPkg::addrWord     pcTarget [`NUM_WARPS]
);
	import gpuPkg::*;

	decodedInstr decoded0;
	decodedInstr decoded1;

	instrDecoder decoder0 (
		.slot    (fetch0),
		.decoded (decoded0)
	);

	instrDecoder decoder1 (
		.slot    (fetch1),
		.decoded (decoded1)
	);

	// Call and jump redirect toward the PC unit
	pcRedirect redirect (
		.clk          (clk),
		.reset        (reset),
		.lane0        (decoded0),
		.lane1        (decoded1),
		.pcUpdateMask (pcUpdateMask),
		.pcValidMask  (pcValidMask),
		.pcTarget     (pcTarget)
	);

	decodeLatch latch (
		.clk      (clk),
		.reset    (reset),
		.lane0In  (decoded0),
		.lane1In  (decoded1),
		.lane0Out (issue0),
		.lane1Out (issue1)
	);

endmodule

`default_nettype wire

// File: logic/gpuPkg.sv
`default_nettype none
`include "gpu_macros.svh"

package gpuPkg;

	typedef logic [`NUM_WARPS-1:0] warpMask; // One-hot warp select or zero
	typedef logic [`INSTR_W-1:0]   instrWord;
	typedef logic [`INSTR_W-1:0]   addrWord; // PC or branch target
	typedef logic [`REG_IDX_W-1:0] regIdx;
	typedef logic [`IMM_W-1:0]     immField; // Not sign extended here

	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluMul  = 4'd2,
		aluAnd  = 4'd3,
		aluOr   = 4'd4,
		aluXor  = 4'd5,
		aluShr  = 4'd6,
		aluShl  = 4'd7,
		aluNone = 4'd15 // No ALU work for this instruction
	} aluOp;

	// One fetch slot as delivered by IF
	typedef struct packed {
		addrWord  pcPlus4;
		instrWord instr;
		warpMask  mask2; // Toward the instruction buffer
		warpMask  mask3; // Toward PC and SIMT stack
	} fetchSlot;

	typedef struct packed {
		instrWord instr;
		addrWord  pcPlus4;
		warpMask  ibMask;
		warpMask  simtMask;
		regIdx    src1;
		regIdx    src2;
		regIdx    dst;
		immField  imm;
		logic     regWrite;
		logic     memRead;
		logic     memWrite;
		logic     sharedMem; // LDS or SWS
		logic     isExit;
		logic     src1Valid;
		logic     src2Valid;
		logic     immValid;
		aluOp     alu;
		logic     isBeq;
		logic     isBlt;
		logic     isCall;
		logic     isRet;
		logic     isJmp;
		logic     dotS; // Opcode bit 4
	} decodedInstr;

endpackage

`default_nettype wire

// File: logic/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_macros.svh"

module instrDecoder (
	input  gpuPkg::fetchSlot    slot,
	output gpuPkg::decodedInstr decoded
);
	import gpuPkg::*;

	// Opcode keys are {op[5], op[3:0]} so the .S bit drops out
	localparam logic [4:0] keyInteger = 5'b0_0000;
	localparam logic [4:0] keyAddi    = 5'b0_1000;
	localparam logic [4:0] keyAndi    = 5'b0_1100;
	localparam logic [4:0] keyOri     = 5'b0_1101;
	localparam logic [4:0] keyXori    = 5'b0_1110;
	localparam logic [4:0] keyLd      = 5'b1_0011;
	localparam logic [4:0] keyLds     = 5'b1_0111;
	localparam logic [4:0] keySw      = 5'b1_1011;
	localparam logic [4:0] keySws     = 5'b1_1111;
	localparam logic [4:0] keyBeq     = 5'b0_0100;
	localparam logic [4:0] keyBlt     = 5'b0_0111;
	localparam logic [4:0] keyCall    = 5'b0_0011;
	localparam logic [4:0] keyRet     = 5'b0_0110;
	localparam logic [4:0] keyJmp     = 5'b0_0010;
	localparam logic [4:0] keyExit    = 5'b1_0001;

	// R-type funct codes
	localparam logic [5:0] functAdd = 6'b100000;
	localparam logic [5:0] functSub = 6'b100010;
	localparam logic [5:0] functMul = 6'b011000;
	localparam logic [5:0] functAnd = 6'b100100;
	localparam logic [5:0] functOr  = 6'b100101;
	localparam logic [5:0] functXor = 6'b100110;
	localparam logic [5:0] functShr = 6'b000010;
	localparam logic [5:0] functShl = 6'b000000;

	logic [5:0] opcode;
	logic [4:0] opKey;
	logic [5:0] funct;
	regIdx      rs;
	regIdx      rt;
	regIdx      rd;

	logic isInteger;
	logic isAddi;
	logic isAndi;
	logic isOri;
	logic isXori;
	logic isLd;
	logic isLds;
	logic isSw;
	logic isSws;
	logic isBeq;
	logic isBlt;
	logic isCall;
	logic isRet;
	logic isJmp;
	logic isExit;
	logic immAlu;
	logic isLoad;
	logic isStore;

	aluOp immOp;
	aluOp functOp;

	assign opcode = slot.instr[31:26];
	assign rs     = slot.instr[25:21];
	assign rt     = slot.instr[20:16];
	assign rd     = slot.instr[15:11];
	assign funct  = slot.instr[5:0];
	assign opKey  = {opcode[5], opcode[3:0]};

	assign isInteger = (opKey == keyInteger);
	assign isAddi    = (opKey == keyAddi);
	assign isAndi    = (opKey == keyAndi);
	assign isOri     = (opKey == keyOri);
	assign isXori    = (opKey == keyXori);
	assign isLd      = (opKey == keyLd);
	assign isLds     = (opKey == keyLds);
	assign isSw      = (opKey == keySw);
	assign isSws     = (opKey == keySws);
	assign isBeq     = (opKey == keyBeq);
	assign isBlt     = (opKey == keyBlt);
	assign isCall    = (opKey == keyCall);
	assign isRet     = (opKey == keyRet);
	assign isJmp     = (opKey == keyJmp);
	assign isExit    = (opKey == keyExit);

	assign immAlu  = isAddi || isAndi || isOri || isXori;
	assign isLoad  = isLd || isLds;
	assign isStore = isSw || isSws;

	always_comb begin
		case (opKey)
			keyAddi: immOp = aluAdd;
			keyAndi: immOp = aluAnd;
			keyOri:  immOp = aluOr;
			keyXori: immOp = aluXor;
			default: immOp = aluNone;
		endcase
	end

	always_comb begin
		case (funct)
			functAdd: functOp = aluAdd;
			functSub: functOp = aluSub;
			functMul: functOp = aluMul;
			functAnd: functOp = aluAnd;
			functOr:  functOp = aluOr;
			functXor: functOp = aluXor;
			functShr: functOp = aluShr;
			functShl: functOp = aluShl;
			default:  functOp = aluNone;
		endcase
	end

	always_comb begin
		decoded.instr    = slot.instr;
		decoded.pcPlus4  = slot.pcPlus4;
		decoded.ibMask   = slot.mask2;
		decoded.simtMask = slot.mask3;

		decoded.src1 = rs;
		decoded.src2 = rt;
		decoded.dst  = (isLoad || immAlu) ? rt : rd; // I-format writes rt
		decoded.imm  = slot.instr[`IMM_W-1:0];

		decoded.regWrite  = isInteger || immAlu || isLoad;
		decoded.memRead   = isLoad;
		decoded.memWrite  = isStore;
		decoded.sharedMem = isLds || isSws;
		decoded.isExit    = isExit;
		decoded.src1Valid = isInteger || immAlu || isLoad || isStore || isBeq || isBlt;
		decoded.src2Valid = isInteger || isStore || isBeq || isBlt; // Stores read rt as data
		decoded.immValid  = immAlu;

		decoded.alu = immAlu ? immOp : functOp;

		decoded.isBeq  = isBeq;
		decoded.isBlt  = isBlt;
		decoded.isCall = isCall;
		decoded.isRet  = isRet;
		decoded.isJmp  = isJmp;
		decoded.dotS   = opcode[4];
	end

endmodule

`default_nettype wire

// File: logic/pcRedirect.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_macros.svh"

module pcRedirect (
	input  logic                clk,
	input  logic                reset,
	input  gpuPkg::decodedInstr lane0,
	input  gpuPkg::decodedInstr lane1,
	output gpuPkg::warpMask     pcUpdateMask,
	output gpuPkg::warpMask     pcValidMask,
	output gpuPkg::addrWord     pcTarget [`NUM_WARPS]
);
	import gpuPkg::*;

	// J-format target below the 6-bit opcode
	localparam int targetW = `INSTR_W - 6;

	logic    redirect0;
	logic    redirect1;
	warpMask hit0;
	warpMask hit1;
	addrWord target0;
	addrWord target1;

	assign redirect0 = lane0.isCall || lane0.isJmp;
	assign redirect1 = lane1.isCall || lane1.isJmp;

	// Warps this slot sends to a new PC
	assign hit0 = redirect0 ? lane0.simtMask : '0;
	assign hit1 = redirect1 ? lane1.simtMask : '0;

	assign target0 = addrWord'(lane0.instr[targetW-1:0]); // Zero extended
	assign target1 = addrWord'(lane1.instr[targetW-1:0]);

	always_ff @(posedge clk) begin
		if (reset) begin
			pcUpdateMask <= '0;
			pcValidMask  <= '0;
		end else begin
			pcUpdateMask <= hit0 | hit1;
			pcValidMask  <= lane0.simtMask | lane1.simtMask;
		end
	end

	// Untouched warps keep their last target
	always_ff @(posedge clk) begin
		for (int w = 0; w < `NUM_WARPS; w++) begin
			if (hit1[w]) begin
				pcTarget[w] <= target1; // Slot 1 wins a shared warp
			end else if (hit0[w]) begin
				pcTarget[w] <= target0;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/decodeStage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageSva (
	input logic                clk,
	input logic                reset,
	input gpuPkg::decodedInstr issue0,
	input gpuPkg::decodedInstr issue1,
	input gpuPkg::decodedInstr decoded0,
	input gpuPkg::decodedInstr decoded1,
	input gpuPkg::warpMask     pcUpdateMask,
	input gpuPkg::warpMask     pcValidMask
);
	import gpuPkg::*;

	warpMask redirectHits; // Warps a call or jump may move this cycle

	assign redirectHits = ((decoded0.isCall || decoded0.isJmp) ? decoded0.simtMask : '0)
		| ((decoded1.isCall || decoded1.isJmp) ? decoded1.simtMask : '0);

	masksClearedByReset: assert property (@(posedge clk)
		reset |=> (issue0.ibMask == '0 && issue0.simtMask == '0 &&
			issue1.ibMask == '0 && issue1.simtMask == '0 &&
			pcUpdateMask == '0 && pcValidMask == '0))
		else $error("Masks not cleared by reset");

	// Per-slot masks select at most one warp
	issueMasksOneHot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(issue0.ibMask) && $onehot0(issue0.simtMask) &&
		$onehot0(issue1.ibMask) && $onehot0(issue1.simtMask))
		else $error("Issue mask with more than one warp set");

	updateWithinValid: assert property (@(posedge clk) disable iff (reset)
		(pcUpdateMask & ~pcValidMask) == '0)
		else $error("pcUpdateMask has a warp outside pcValidMask");

	updateOnlyOnRedirect: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (pcUpdateMask & ~$past(redirectHits)) == '0)
		else $error("pcUpdateMask set for a slot that was not a call or jump");

endmodule

bind decodeStage decodeStageSva checks (
	.clk          (clk),
	.reset        (reset),
	.issue0       (issue0),
	.issue1       (issue1),
	.decoded0     (decoded0),
	.decoded1     (decoded1),
	.pcUpdateMask (pcUpdateMask),
	.pcValidMask  (pcValidMask)
);

`default_nettype wire

// File: sim/decodeStage_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_macros.svh"

module decodeStage_tb;
	import gpuPkg::*;

	localparam int rowWords       = 11; // Words per pattern row
	localparam int numPatternRows = 20;
	localparam int numRandomRows  = 16;
	localparam int resetTimeout   = 64;
	localparam logic [31:0] lfsrSeed = 32'h1dd1_6132;
	localparam logic [31:0] lfsrTaps = 32'h8020_0003;

	logic        clk;
	logic        reset;
	fetchSlot    fetch0;
	fetchSlot    fetch1;
	decodedInstr issue0;
	decodedInstr issue1;
	warpMask     pcUpdateMask;
	warpMask     pcValidMask;
	addrWord     pcTarget [`NUM_WARPS];

	logic [31:0] patMem [0:numPatternRows*rowWords-1];
	logic [31:0] expWord0; // Expected decode of the pair now in flight
	logic [31:0] expWord1;
	warpMask     expUpd;
	logic [31:0] lfsrState;
	int          errorCount = 0;
	int          checkCount = 0;

	decodeStage UUT (
		.clk          (clk),
		.reset        (reset),
		.fetch0       (fetch0),
		.fetch1       (fetch1),
		.issue0       (issue0),
		.issue1       (issue1),
		.pcUpdateMask (pcUpdateMask),
		.pcValidMask  (pcValidMask),
		.pcTarget     (pcTarget)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ lfsrTaps;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	function automatic logic [15:0] packFlags(input decodedInstr d);
		return {2'b00, d.regWrite, d.memRead, d.memWrite, d.sharedMem, d.isExit,
			d.src1Valid, d.src2Valid, d.immValid, d.isBeq, d.isBlt, d.isCall,
			d.isRet, d.isJmp, d.dotS};
	endfunction

	// Slot 1 wins a warp that both slots redirect
	function automatic addrWord expectedTarget(input int w);
		if (fetch1.mask3[w] && (expWord1[19] || expWord1[17])) begin
			return addrWord'(fetch1.instr[25:0]);
		end
		return addrWord'(fetch0.instr[25:0]);
	endfunction

	task automatic checkField(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			errorCount++;
			$display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkSlot(input int lane, input decodedInstr got, input fetchSlot sent,
			input logic [31:0] expWord);
		string tag;
		tag = $sformatf("issue%0d", lane);
		checkField({tag, ".ibMask"}, 32'(got.ibMask), 32'(sent.mask2));
		checkField({tag, ".simtMask"}, 32'(got.simtMask), 32'(sent.mask3));
		if (sent.mask2 != '0 || sent.mask3 != '0) begin // Data is don't-care without a warp
			checkField({tag, ".instr"}, got.instr, sent.instr);
			checkField({tag, ".pcPlus4"}, got.pcPlus4, sent.pcPlus4);
			checkField({tag, ".src1"}, 32'(got.src1), 32'(sent.instr[25:21]));
			checkField({tag, ".src2"}, 32'(got.src2), 32'(sent.instr[20:16]));
			checkField({tag, ".imm"}, 32'(got.imm), 32'(sent.instr[15:0]));
			checkField({tag, ".flags"}, 32'(packFlags(got)), 32'(expWord[31:16]));
			checkField({tag, ".alu"}, 32'(got.alu), 32'(expWord[11:8]));
			checkField({tag, ".dst"}, 32'(got.dst), 32'(expWord[4:0]));
		end
	endtask

	// Compares against the pair still on the inputs, driven one cycle ago
	task automatic checkOutputs();
		checkSlot(0, issue0, fetch0, expWord0);
		checkSlot(1, issue1, fetch1, expWord1);
		checkField("pcUpdateMask", 32'(pcUpdateMask), 32'(expUpd));
		checkField("pcValidMask", 32'(pcValidMask), 32'(fetch0.mask3 | fetch1.mask3));
		for (int w = 0; w < `NUM_WARPS; w++) begin
			if (expUpd[w]) begin
				checkField($sformatf("pcTarget[%0d]", w), pcTarget[w], expectedTarget(w));
			end
		end
	endtask

	task automatic checkIdle();
		checkField("issue0.ibMask", 32'(issue0.ibMask), 32'h0);
		checkField("issue0.simtMask", 32'(issue0.simtMask), 32'h0);
		checkField("issue1.ibMask", 32'(issue1.ibMask), 32'h0);
		checkField("issue1.simtMask", 32'(issue1.simtMask), 32'h0);
		checkField("pcUpdateMask", 32'(pcUpdateMask), 32'h0);
		checkField("pcValidMask", 32'(pcValidMask), 32'h0);
	endtask

	task automatic loadPatternRow(input int row);
		int base;
		base = row * rowWords;
		fetch0.pcPlus4 = patMem[base];
		fetch0.instr   = patMem[base+1];
		fetch0.mask2   = patMem[base+2][7:0];
		fetch0.mask3   = patMem[base+3][7:0];
		fetch1.pcPlus4 = patMem[base+4];
		fetch1.instr   = patMem[base+5];
		fetch1.mask2   = patMem[base+6][7:0];
		fetch1.mask3   = patMem[base+7][7:0];
		expWord0       = patMem[base+8];
		expWord1       = patMem[base+9];
		expUpd         = patMem[base+10][7:0];
	endtask

	// Random ADDI on a random warp, fields pass straight through
	task automatic makeRandomSlot(output fetchSlot slot, output logic [31:0] expWord);
		logic        dotS;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		logic [2:0]  warp;
		slot.pcPlus4 = takeBits(32);
		dotS = 1'(takeBits(1));
		rs   = 5'(takeBits(5));
		rt   = 5'(takeBits(5));
		imm  = 16'(takeBits(16));
		warp = 3'(takeBits(3));
		slot.instr = {1'b0, dotS, 4'b1000, rs, rt, imm};
		slot.mask2 = warpMask'(1 << warp);
		slot.mask3 = slot.mask2;
		expWord = {16'h2140 | 16'(dotS), 4'h0, 4'(aluAdd), 3'b000, rt}; // Writes rt
	endtask

	task automatic loadRandomRow();
		makeRandomSlot(fetch0, expWord0);
		makeRandomSlot(fetch1, expWord1);
		expUpd = '0; // No redirect from ADDI
	endtask

	// Masks stay clear while reset is held, even with busy inputs
	task automatic waitResetDone(output logic released);
		int cycles;
		cycles = 0;
		while (reset !== 1'b0 && cycles < resetTimeout) begin
			@(posedge clk);
			#1;
			cycles++;
			if (reset === 1'b1) begin
				checkIdle();
			end
		end
		released = (reset === 1'b0);
	endtask

	task automatic finishRun();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	initial begin
		logic released;
		fetch0    = {32'h0000_1000, 32'h0eab_cdef, 8'h01, 8'h01}; // CALL held during reset
		fetch1    = {32'h0000_1004, 32'h0923_4567, 8'h02, 8'h02}; // J held during reset
		expWord0  = '0;
		expWord1  = '0;
		expUpd    = '0;
		lfsrState = lfsrSeed;
		$readmemh("sim/decode_patterns.txt", patMem);
		if ($isunknown(patMem[0])) begin
			errorCount++;
			$display("Could not read stimulus from sim/decode_patterns.txt");
		end
		waitResetDone(released);
		if (released) begin
			#1;
			fetch0 = '0; // Idle pair after reset
			fetch1 = '0;
			@(posedge clk);
			#2;
			checkIdle(); // Idle inputs after reset keep every mask clear
			for (int r = 0; r < numPatternRows + numRandomRows; r++) begin
				if (r > 0) begin
					@(posedge clk);
					#2;
					checkOutputs();
				end
				if (r < numPatternRows) begin
					loadPatternRow(r);
				end else begin
					loadRandomRow();
				end
			end
			@(posedge clk);
			#2;
			checkOutputs();
		end else begin
			errorCount++;
			$display("Timeout: reset was not released within %0d cycles", resetTimeout);
		end
		finishRun();
	end

endmodule

`default_nettype wire

// File: sim/decode_patterns.txt
// pc0 instr0 mask2_0 mask3_0 pc1 instr1 mask2_1 mask3_1 exp0 exp1 expUpdateMask
// exp = {flags, 4'h0, alu, 3'b0, dst}, flags msb first: 00 regWrite memRead memWrite
// sharedMem isExit src1Valid src2Valid immValid isBeq isBlt isCall isRet isJmp dotS
00001004 00221820 01 01 00001008 00221822 02 02 21800003 21800103 00
0000100c 00221818 04 04 00001010 00221824 08 08 21800203 21800303 00
00001014 00221825 10 10 00001018 00221826 20 20 21800403 21800503 00
0000101c 00221802 40 40 00001020 00221800 80 80 21800603 21800703 00
00001024 40221820 01 01 00001028 40221800 02 02 21810003 21810703 00
0000102c 0022183f 04 04 00001030 40221818 08 08 21800f03 21810203 00
00001034 20221234 10 10 00001038 30221234 20 20 21400002 21400302 00
0000103c 34221234 40 40 00001040 38221234 80 80 21400402 21400502 00
00001044 60221234 01 01 00001048 70221234 02 02 21410002 21410302 00
0000104c 74221234 04 04 00001050 78221234 08 08 21410402 21410502 00
00001054 8c221234 10 10 00001058 9c220010 20 20 31000f02 35000f02 00
0000105c ac220010 40 40 00001060 bc221234 80 80 09800f00 0d800f02 00
00001064 cc220010 01 01 00001068 10220010 02 02 31010f02 01a00f00 00
0000106c 1c220010 04 04 00001070 18220010 08 08 01900f00 00040f00 00
00001074 84220010 10 10 00001078 50220010 20 20 02000f00 01a10f00 00
0000107c 0eabcdef 20 20 00001080 58220010 40 40 00080f19 00050f00 20
00001084 00221820 01 01 00001088 09234567 80 80 21800003 00020f08 80
0000108c 0eabcdef 08 08 00001090 09234567 08 08 00080f19 00020f08 08
00001094 0eabcdef 04 00 00001098 20221234 00 00 00080f19 21400002 00
0000109c 09234567 02 02 000010a0 0eabcdef 10 10 00020f08 00080f19 12
